// File: src/xc_params.svh
`ifndef XC_PARAMS_SVH
`define XC_PARAMS_SVH

// sizes of the two-line correlator core.

`define XC_NUM_LAGS      4     // lag counters per run.
`define XC_DELAY_SIZE    64    // taps of the line b history.
`define XC_COUNT_BITS    16    // width of every counter.

// longest window is 2^15 cycles so a 16 bit count never wraps.
`define XC_MAX_LOG2      15    // requests above this clamp here.
`define XC_DEFAULT_LOG2  4     // window exponent after reset.

`define XC_SYNC_BYTE     8'hA5 // first byte of every result frame.

`endif

// File: src/xc_pkg.sv
`include "xc_params.svh"

package xc_pkg;

	// command opcode in bits 7:6 of the command byte.
	typedef enum logic [1:0] {
		OP_NOP     = 2'd0, // ignored.
		OP_SET_LEN = 2'd1, // set integration exponent.
		OP_RUN     = 2'd2, // start a run at a lag offset.
		OP_ABORT   = 2'd3  // stop the current run.
	} xc_op_e;

	// set_len view of the command byte.
	typedef struct packed {
		xc_op_e     op;         // opcode.
		logic [5:0] log2_len;   // window is 2^log2_len cycles.
	} xc_len_cmd_t;

	// run view of the command byte.
	typedef struct packed {
		xc_op_e     op;         // opcode.
		logic [5:0] lag_offset; // first tap of the lag block.
	} xc_run_cmd_t;

	// the low six bits mean a length or an offset depending on op.
	typedef union packed {
		xc_len_cmd_t len;       // read for set_len.
		xc_run_cmd_t run;       // read for run.
	} xc_cmd_u;

	// run configuration after clamping.
	typedef struct packed {
		logic [3:0] log2_len;   // 1 to 15.
		logic [5:0] lag_offset; // 0 to 60.
	} xc_cfg_t;

	// result of one integration window.
	typedef struct packed {
		logic [`XC_COUNT_BITS-1:0]                   count_a;   // pulses on line a.
		logic [`XC_COUNT_BITS-1:0]                   count_b;   // pulses on line b.
		logic [`XC_NUM_LAGS-1:0][`XC_COUNT_BITS-1:0] lag_count; // a with delayed b.
	} xc_counts_t;

endpackage

// File: src/xc_cmd_decode.sv
`timescale 1ns/1ps

`include "xc_params.svh"

module xc_cmd_decode (
	input  logic            clki,
	input  logic            arst_n,
	input  logic            cmd_valid,  // one command byte per strobe.
	input  xc_pkg::xc_cmd_u cmd_data,
	input  logic            busy,       // engine running or frame going out.
	output xc_pkg::xc_cfg_t cfg,
	output logic            start,
	output logic            abort
);

	import xc_pkg::*;

	// highest offset that keeps offset+3 inside the delay line.
	localparam int MAX_OFF = `XC_DELAY_SIZE - `XC_NUM_LAGS;

	xc_op_e     op;          // opcode shared by both views.
	logic [3:0] len_clamp;   // length limited to 1..15.
	logic [5:0] off_clamp;   // offset limited to 0..60.

	assign op = cmd_data.len.op; // same bits in either view.

	// clamp the low bits under the view the opcode selects.
	always_comb begin
		if (cmd_data.len.log2_len == 6'd0) begin
			len_clamp = 4'd1;                               // zero length makes no sense.
		end else if (cmd_data.len.log2_len > 6'(`XC_MAX_LOG2)) begin
			len_clamp = 4'(`XC_MAX_LOG2);                   // keep counts from wrapping.
		end else begin
			len_clamp = cmd_data.len.log2_len[3:0];
		end
		if (cmd_data.run.lag_offset > 6'(MAX_OFF)) begin
			off_clamp = 6'(MAX_OFF);
		end else begin
			off_clamp = cmd_data.run.lag_offset;
		end
	end

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			cfg.log2_len   <= 4'(`XC_DEFAULT_LOG2);
			cfg.lag_offset <= 6'd0;
			start          <= 1'b0;
			abort          <= 1'b0;
		end else begin
			start <= 1'b0;                                  // pulses last one cycle.
			abort <= 1'b0;
			if (cmd_valid) begin
				case (op)
					OP_SET_LEN: if (!busy) cfg.log2_len <= len_clamp;
					OP_RUN: begin
						if (!busy) begin                    // run while busy is dropped.
							cfg.lag_offset <= off_clamp;
							start          <= 1'b1;
						end
					end
					OP_ABORT: abort <= 1'b1;                // engine decides if it applies.
					default: ;                              // nop.
				endcase
			end
		end
	end

endmodule

// File: src/xc_lag_engine.sv
`timescale 1ns/1ps

`include "xc_params.svh"

module xc_lag_engine (
	input  logic               clki,
	input  logic               arst_n,
	input  xc_pkg::xc_cfg_t    cfg,         // sampled together with start.
	input  logic               start,
	input  logic               abort,
	input  logic               line_a,
	input  logic               line_b,
	input  logic               sending,     // frame stage is busy.
	output logic               integrating,
	output logic               busy,
	output logic               done,
	output xc_pkg::xc_counts_t counts
);

	import xc_pkg::*;

	localparam int CNT_W   = `XC_COUNT_BITS;
	localparam int TIMER_W = `XC_MAX_LOG2 + 1;  // holds 2^15.
	localparam int DLY     = `XC_DELAY_SIZE;
	localparam int NLAG    = `XC_NUM_LAGS;

	logic [DLY-2:0]     dly_q;      // older line b samples.
	logic [DLY-1:0]     taps;       // tap d is line b from d edges back.
	logic [TIMER_W-1:0] timer_q;    // edges left in the window.
	logic [5:0]         off_q;      // offset captured at start.
	logic [NLAG-1:0]    lag_hit;    // coincidence per lag this edge.
	xc_counts_t         counts_q;
	logic               cnt_over;   // some counter past the window size.

	// tap 0 is the live input so offset 0 is a plain a&b coincidence.
	assign taps = {dly_q, line_b};

	// line b shifts in on every edge whether a run is active or not.
	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			dly_q <= '0;
		end else begin
			dly_q <= taps[DLY-2:0];
		end
	end

	always_comb begin
		for (int k = 0; k < NLAG; k++) begin
			lag_hit[k] = line_a & taps[off_q + 6'(k)]; // offset is clamped so no wrap.
		end
	end

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			integrating <= 1'b0;
			done        <= 1'b0;
			timer_q     <= '0;
			off_q       <= '0;
			counts_q    <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				integrating <= 1'b1;
				timer_q     <= TIMER_W'(1) << cfg.log2_len; // 2^L sampling edges.
				off_q       <= cfg.lag_offset;
				counts_q    <= '0;                           // fresh window.
			end else if (integrating && abort) begin
				integrating <= 1'b0;                         // no done so no frame.
				counts_q    <= '0;
			end else if (integrating) begin
				counts_q.count_a <= counts_q.count_a + CNT_W'(line_a);
				counts_q.count_b <= counts_q.count_b + CNT_W'(line_b);
				for (int k = 0; k < NLAG; k++) begin
					counts_q.lag_count[k] <= counts_q.lag_count[k] + CNT_W'(lag_hit[k]);
				end
				timer_q <= timer_q - TIMER_W'(1);
				if (timer_q == TIMER_W'(1)) begin
					integrating <= 1'b0;                     // last sample taken.
					done        <= 1'b1;                     // counts are final now.
				end
			end
		end
	end

	assign counts = counts_q;                      // frozen between windows.
	assign busy   = integrating | done | sending;  // done closes the gap to sending.

	// any counter above 2^15 means the window ran long.
	always_comb begin
		cnt_over = (counts_q.count_a > (CNT_W'(1) << `XC_MAX_LOG2)) ||
			(counts_q.count_b > (CNT_W'(1) << `XC_MAX_LOG2));
		for (int k = 0; k < NLAG; k++) begin
			if (counts_q.lag_count[k] > (CNT_W'(1) << `XC_MAX_LOG2)) begin
				cnt_over = 1'b1;
			end
		end
	end

	// the decoder must hold off runs while busy.
	a_no_start_in_run : assert property (@(posedge clki) disable iff (!arst_n)
		start |-> !integrating);

	a_count_bound : assert property (@(posedge clki) disable iff (!arst_n)
		!cnt_over);

endmodule

// File: src/xc_frame_out.sv
`timescale 1ns/1ps

`include "xc_params.svh"

module xc_frame_out (
	input  logic               clki,
	input  logic               arst_n,
	input  logic               done,       // counts valid this cycle.
	input  xc_pkg::xc_counts_t counts,
	output logic               sending,
	output logic               out_valid,
	output logic [7:0]         out_data
);

	import xc_pkg::*;

	localparam int CNT_W       = `XC_COUNT_BITS;
	localparam int NLAG        = `XC_NUM_LAGS;
	localparam int FRAME_BYTES = 1 + (2 + NLAG) * (CNT_W / 8); // 13 bytes.
	localparam int FRAME_BITS  = FRAME_BYTES * 8;
	localparam int HEAD_BITS   = 8 + 2 * CNT_W;                 // sync, a and b.

	xc_counts_t            lat_q;    // snapshot of the window result.
	logic [3:0]            idx_q;    // byte being sent.
	logic [FRAME_BITS-1:0] frame_w;  // whole frame, first byte at the top.

	// snapshot only. the engine may clear its counts afterwards.
	always_ff @(posedge clki) begin
		if (done) begin
			lat_q <= counts;
		end
	end

	always_ff @(posedge clki or negedge arst_n) begin
		if (!arst_n) begin
			sending <= 1'b0;
			idx_q   <= '0;
		end else if (done) begin
			sending <= 1'b1;                             // first byte next cycle.
			idx_q   <= '0;
		end else if (sending) begin
			if (idx_q == 4'(FRAME_BYTES - 1)) begin
				sending <= 1'b0;                         // last byte went out.
			end
			idx_q <= idx_q + 4'd1;
		end
	end

	// lags go out in index order which is the reverse of their packing.
	always_comb begin
		frame_w = '0;
		frame_w[FRAME_BITS-1 -: HEAD_BITS] = {`XC_SYNC_BYTE, lat_q.count_a, lat_q.count_b};
		for (int k = 0; k < NLAG; k++) begin
			frame_w[FRAME_BITS-HEAD_BITS-1-k*CNT_W -: CNT_W] = lat_q.lag_count[k];
		end
	end

	// high byte of each counter comes first.
	assign out_data  = frame_w[(FRAME_BYTES - 1 - int'(idx_q)) * 8 +: 8];
	assign out_valid = sending;                          // one byte per cycle.

	// a second result before the frame ends would be lost.
	a_done_while_idle : assert property (@(posedge clki) disable iff (!arst_n)
		done |-> !sending);

endmodule

// File: src/xc_firmware.sv
`timescale 1ns/1ps

module xc_firmware (
	input  logic       clki,
	input  logic       arst_n,
	input  logic       cmd_valid,    // command byte strobe.
	input  logic [7:0] cmd_data,
	input  logic       line_a,       // photon pulses line a.
	input  logic       line_b,       // photon pulses line b.
	output logic       integrating,  // window open.
	output logic       out_valid,    // result byte strobe.
	output logic [7:0] out_data
);

	import xc_pkg::*;

	xc_cfg_t    cfg;       // clamped run setup.
	logic       start;     // run request.
	logic       abort;     // stop request.
	logic       busy;      // engine or frame active.
	logic       done;      // window finished.
	logic       sending;   // frame in flight.
	xc_counts_t counts;    // window result.

	xc_cmd_decode u_decode (
		.clki      (clki),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd_data  (cmd_data),     // byte reinterpreted as the command union.
		.busy      (busy),
		.cfg       (cfg),
		.start     (start),
		.abort     (abort)
	);

	xc_lag_engine u_engine (
		.clki        (clki),
		.arst_n      (arst_n),
		.cfg         (cfg),
		.start       (start),
		.abort       (abort),
		.line_a      (line_a),
		.line_b      (line_b),
		.sending     (sending),
		.integrating (integrating),
		.busy        (busy),
		.done        (done),
		.counts      (counts)
	);

	xc_frame_out u_frame (
		.clki      (clki),
		.arst_n    (arst_n),
		.done      (done),
		.counts    (counts),
		.sending   (sending),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

// File: verif/xc_tb_tasks.svh
`ifndef XC_TB_TASKS_SVH
`define XC_TB_TASKS_SVH

task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("*** TEST FAILED ***");
	$fatal(1, "stopped at the first failure");
endtask

task automatic compare_counts(input xc_counts_t got, input xc_counts_t exp, input string what);
	if (got !== exp) begin
		fail_run($sformatf("error at %0t: %s got %h expected %h", $time, what, got, exp));
	end
endtask

task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
	if (got !== exp) begin
		fail_run($sformatf("error at %0t: %s got %h expected %h", $time, what, got, exp));
	end
endtask

task automatic compare_cycles(input int got, input int exp, input string what);
	if (got != exp) begin
		fail_run($sformatf("error at %0t: %s got %0d expected %0d", $time, what, got, exp));
	end
endtask

task automatic send_cmd(input xc_cmd_u c);
	@(posedge clki);
	cmd_valid <= 1'b1;
	cmd_data  <= c;
	@(posedge clki);
	cmd_valid <= 1'b0;                             // single cycle strobe.
endtask

task automatic set_length(input logic [5:0] l);
	xc_cmd_u c;
	c.len.op       = OP_SET_LEN;
	c.len.log2_len = l;
	exp_log2 = (l == 6'd0) ? 1 : ((l > 6'd15) ? 15 : int'(l)); // 1..15.
	send_cmd(c);
endtask

// sends a run and returns at the first edge with integrating high.
task automatic start_run(input logic [5:0] off);
	xc_cmd_u c;
	int      n;
	c.run.op         = OP_RUN;
	c.run.lag_offset = off;
	exp_off = (off > 6'd60) ? 60 : int'(off);    // offset+3 stays on the delay line.
	run_id++;
	n = 0;
	send_cmd(c);
	@(posedge clki);
	while (!integrating && n < 4) begin
		@(posedge clki);
		n++;
	end
	if (!integrating) begin
		fail_run("integrating never rose after the run command");
	end
endtask

task automatic finish_run(output xc_counts_t got);
	logic [7:0] frame [13];
	while (integrating) begin
		@(posedge clki);
	end
	compare_cycles(integ_seen, 1 << exp_log2, "window length");
	if (out_valid) begin
		fail_run("out_valid was already high in the cycle integrating fell");
	end
	for (int i = 0; i < 13; i++) begin
		@(posedge clki);
		if (!out_valid) begin
			fail_run($sformatf("out_valid missing for frame byte %0d", i));
		end
		frame[i] = out_data;
	end
	@(posedge clki);
	if (out_valid) begin
		fail_run("out_valid stayed high after the 13th frame byte");
	end
	compare_byte(frame[0], `XC_SYNC_BYTE, "sync byte");
	got.count_a = {frame[1], frame[2]};          // high byte first.
	got.count_b = {frame[3], frame[4]};
	for (int k = 0; k < NLAG; k++) begin
		got.lag_count[k] = {frame[5 + 2 * k], frame[6 + 2 * k]};
	end
	compare_counts(got, exp_counts, "frame counts");
endtask

task automatic test_length_timing();
	xc_counts_t got;
	line_mode <= 2'd1;
	set_length(6'd3);
	start_run(6'd0);
	finish_run(got);                             // 8 cycle window.
endtask

task automatic test_random_offset0();
	xc_counts_t got;
	set_length(6'd6);
	start_run(6'd0);
	finish_run(got);
endtask

task automatic test_offset_view();
	xc_counts_t got;
	start_run(6'd20);                            // taps 20..23.
	finish_run(got);
	start_run(6'd63);                            // clamps to 60.
	finish_run(got);
endtask

task automatic test_length_clamp();
	xc_counts_t got;
	xc_counts_t all_hit;
	all_hit.count_a = 16'h8000;
	all_hit.count_b = 16'h8000;
	for (int k = 0; k < NLAG; k++) begin
		all_hit.lag_count[k] = 16'h8000;
	end
	line_mode <= 2'd2;
	repeat (70) @(posedge clki);                 // fill the delay line with ones.
	set_length(6'd40);
	start_run(6'd7);
	finish_run(got);
	compare_counts(got, all_hit, "saturated window counts");
endtask

task automatic test_abort_busy();
	xc_counts_t got;
	xc_cmd_u    c;
	line_mode <= 2'd1;
	set_length(6'd6);
	start_run(6'd12);
	repeat (10) @(posedge clki);
	c.run.op         = OP_RUN;
	c.run.lag_offset = 6'd40;
	send_cmd(c);                                 // dropped while busy.
	finish_run(got);
	start_run(6'd3);
	repeat (20) @(posedge clki);
	c.run.op = OP_ABORT;
	send_cmd(c);                                 // abort pulses in the next cycle.
	repeat (2) @(posedge clki);
	if (integrating) begin
		fail_run("integrating stayed high after abort");
	end
	repeat (40) begin
		@(posedge clki);
		if (out_valid) begin
			fail_run("a frame was sent after the run was aborted");
		end
	end
	start_run(6'd9);
	finish_run(got);
endtask

task automatic run_all_tests();
	test_length_timing();
	test_random_offset0();
	test_offset_view();
	test_length_clamp();
	test_abort_busy();
endtask

`endif

// File: verif/xc_tb.sv
`timescale 1ns/1ps

`include "xc_params.svh"

module xc_tb;

	import xc_pkg::*;

	localparam int CNT_W = `XC_COUNT_BITS;
	localparam int NLAG  = `XC_NUM_LAGS;
	// all windows of the sequence, one frame per finished run, slack for commands.
	localparam int TIMEOUT_CYCLES = (8 + 7 * 64 + 32768) + 7 * 13 + 2000;

	logic       clki      = 1'b0;
	logic       arst_n    = 1'b0;
	logic       cmd_valid = 1'b0;
	logic [7:0] cmd_data  = 8'h00;
	logic       line_a    = 1'b0;
	logic       line_b    = 1'b0;
	logic       integrating;
	logic       out_valid;
	logic [7:0] out_data;

	logic [1:0]  line_mode   = 2'd0;              // 0 low, 1 lfsr, 2 high.
	logic [15:0] lfsr_q      = 16'd65;            // seed.
	logic        hist_b [64] = '{default: 1'b0};  // line b by edge number.
	int          edge_idx    = 0;                 // edges since reset release.
	int          run_id      = 0;                 // bumped once per run.
	int          run_seen    = 0;
	int          exp_off     = 0;                 // clamped offset of the run.
	int          exp_log2    = 4;                 // clamped window exponent.
	int          integ_seen  = 0;                 // edges with integrating high.
	int          cycle_cnt   = 0;
	xc_counts_t  exp_counts  = '0;                // reference result.

	xc_firmware DUT (.*);

	initial begin
		forever #4 clki = ~clki;                   // 8 ns period.
	end

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	always @(posedge clki) begin
		case (line_mode)
			2'd1: begin
				lfsr_q = lfsr_next(lfsr_q);            // one step per bit.
				line_a <= lfsr_q[0];
				lfsr_q = lfsr_next(lfsr_q);
				line_b <= lfsr_q[0];
			end
			2'd2: begin
				line_a <= 1'b1;
				line_b <= 1'b1;
			end
			default: begin
				line_a <= 1'b0;
				line_b <= 1'b0;
			end
		endcase
	end

	// reference model. sees the same pre-edge values as the DUT.
	always @(posedge clki) begin
		if (run_id != run_seen) begin
			exp_counts = '0;                           // new run, fresh window.
			integ_seen = 0;
			run_seen   = run_id;
		end
		if (arst_n) begin
			hist_b[6'(edge_idx)] = line_b;             // tap 0 is the live sample.
			if (integrating) begin
				integ_seen++;
				exp_counts.count_a = exp_counts.count_a + CNT_W'(line_a);
				exp_counts.count_b = exp_counts.count_b + CNT_W'(line_b);
				for (int k = 0; k < NLAG; k++) begin
					if (line_a && hist_b[6'(edge_idx - exp_off - k)]) begin
						exp_counts.lag_count[k] = exp_counts.lag_count[k] + CNT_W'(1);
					end
				end
			end
			edge_idx++;
		end
	end

	`include "xc_tb_tasks.svh"

	task automatic watch_cycles();
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clki);
			cycle_cnt++;
		end
		fail_run($sformatf("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES));
	endtask

	initial begin
		repeat (10) @(posedge clki);               // reset for 10 cycles.
		arst_n <= 1'b1;
		fork
			run_all_tests();
			watch_cycles();
		join_any
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: files.f
+incdir+src
+incdir+verif
src/xc_pkg.sv
src/xc_cmd_decode.sv
src/xc_lag_engine.sv
src/xc_frame_out.sv
src/xc_firmware.sv
verif/xc_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module xc_tb -f files.f -Mdir obj_dir
	-./obj_dir/Vxc_tb > sim.log 2>&1
	@cat sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" sim.log; then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
